//--- bench/tb_tests.svh
function automatic logic [NUM_VC-1:0] onehot(input int vc);
    logic [NUM_VC-1:0] sel;
    sel     = '0;
    sel[vc] = 1'b1;
    return sel;
endfunction

// flags the buffer should show, from the model queue counts
function automatic logic [NUM_VC-1:0] expected_flags();
    logic [NUM_VC-1:0] flags;
    for (int v = 0; v < NUM_VC; v++) begin
        flags[v] = (model_q[v].size() != 0);
    end
    return flags;
endfunction

task automatic drive_inputs(input logic wr, input logic [NUM_VC-1:0] wr_sel, input logic rd,
                            input logic [NUM_VC-1:0] rd_sel, input logic [NUM_VC-1:0] ssa,
                            input flit_type_e t, input logic [PAYLOAD_WIDTH-1:0] p);
    @(posedge clk);
    wr_en        <= wr;
    vc_num_wr    <= wr_sel;
    rd_en        <= rd;
    vc_num_rd    <= rd_sel;
    ssa_rd       <= ssa;
    flit_type_in <= t;
    payload_in   <= p;
endtask

task automatic drive_idle();
    drive_inputs(1'b0, '0, 1'b0, '0, '0, flit_head, '0);
endtask

task automatic random_flit(output flit_type_e t, output logic [PAYLOAD_WIDTH-1:0] p);
    logic [FLIT_TYPE_WIDTH-1:0] r;
    r = FLIT_TYPE_WIDTH'($random(seed));
    t = flit_type_e'(r);
    p = PAYLOAD_WIDTH'($random(seed));
endtask

task automatic write_random(input int vc);
    flit_type_e               t;
    logic [PAYLOAD_WIDTH-1:0] p;
    random_flit(t, p);
    drive_inputs(1'b1, onehot(vc), 1'b0, '0, '0, t, p);
    model_q[vc].push_back({t, p});
endtask

// read strobe, then one idle edge, data is checked after the read edge
task automatic read_and_check(input int vc, input string tag);
    logic [DATA_W-1:0] exp_word;
    drive_inputs(1'b0, '0, 1'b1, onehot(vc), '0, flit_head, '0);
    drive_idle();
    @(negedge clk);
    if (model_q[vc].size() == 0) begin
        $display("error at %0t: %s reads vc %0d while the model holds no flit", $time, tag, vc);
        errors++;
    end else begin
        exp_word = model_q[vc].pop_front();
        check_flit(flit_type_e'(exp_word[DATA_W-1 -: FLIT_TYPE_WIDTH]),
                   exp_word[PAYLOAD_WIDTH-1:0], tag);
    end
endtask

task automatic test_reset_state();
    int err_before;
    err_before = errors;
    @(negedge clk);
    check_not_empty('0, "flags after reset");
    report_test("reset state", err_before);
endtask

task automatic test_fifo_order();
    int err_before;
    err_before = errors;
    for (int i = 0; i < VC_DEPTH; i++) begin
        write_random(0);
    end
    drive_idle();
    @(negedge clk);
    check_not_empty(expected_flags(), "vc 0 filled");
    for (int i = 0; i < VC_DEPTH; i++) begin
        read_and_check(0, "vc 0 fifo order");
    end
    check_not_empty(expected_flags(), "vc 0 drained");
    report_test("single vc fifo order", err_before);
endtask

task automatic test_vc_isolation();
    int err_before;
    err_before = errors;
    for (int r = 0; r < VC_DEPTH; r++) begin
        for (int v = 0; v < NUM_VC; v++) begin
            write_random(v);  // interleaved over all vcs
        end
    end
    drive_idle();
    @(negedge clk);
    check_not_empty(expected_flags(), "all vcs filled");
    for (int v = NUM_VC - 1; v >= 0; v--) begin
        for (int k = 0; k < VC_DEPTH; k++) begin
            read_and_check(v, "vc isolation read");
            check_not_empty(expected_flags(), "flags while draining");
        end
    end
    report_test("vc isolation", err_before);
endtask

task automatic test_pointer_wrap();
    int err_before;
    err_before = errors;
    for (int i = 0; i < 3 * VC_DEPTH / 2; i++) begin
        write_random(1);
        write_random(1);
        read_and_check(1, "wrap read first");
        read_and_check(1, "wrap read second");
    end
    check_not_empty(expected_flags(), "vc 1 empty after wrap");
    report_test("pointer wrap", err_before);
endtask

task automatic test_ssa_bypass();
    int                       err_before;
    flit_type_e               t;
    logic [PAYLOAD_WIDTH-1:0] p;
    err_before = errors;
    random_flit(t, p);
    // written and consumed at the same edge, never enters the model
    drive_inputs(1'b1, onehot(2), 1'b0, '0, onehot(2), t, p);
    drive_idle();
    @(negedge clk);
    check_flit(t, p, "ssa bypass flit");
    check_not_empty(expected_flags(), "vc 2 empty after ssa");
    drive_idle();
    @(negedge clk);
    check_not_empty(expected_flags(), "vc 2 still empty");
    report_test("ssa bypass", err_before);
endtask

task automatic test_read_write_same_edge();
    int                       err_before;
    int                       vc;
    flit_type_e               t;
    logic [PAYLOAD_WIDTH-1:0] p;
    logic [DATA_W-1:0]        exp_word;
    err_before = errors;
    vc         = NUM_VC - 1;
    write_random(vc);
    write_random(vc);
    random_flit(t, p);
    drive_inputs(1'b1, onehot(vc), 1'b1, onehot(vc), '0, t, p);
    drive_idle();
    @(negedge clk);
    exp_word = model_q[vc].pop_front();  // older flit comes out
    model_q[vc].push_back({t, p});
    check_flit(flit_type_e'(exp_word[DATA_W-1 -: FLIT_TYPE_WIDTH]),
               exp_word[PAYLOAD_WIDTH-1:0], "read on simultaneous access");
    check_not_empty(expected_flags(), "vc holds two flits");
    read_and_check(vc, "remaining flit one");
    read_and_check(vc, "remaining flit two");
    check_not_empty(expected_flags(), "vc empty after two reads");
    report_test("simultaneous read and write", err_before);
endtask

//--- bench/tb_vc_flit_buffer.sv
`timescale 1ns/1ps

module tb_vc_flit_buffer import flit_buffer_pkg::*; ();

    localparam int NUM_VC         = DEF_NUM_VC;
    localparam int VC_DEPTH       = DEF_VC_DEPTH;
    localparam int PAYLOAD_WIDTH  = DEF_PAYLOAD_WIDTH;
    localparam int DATA_W         = FLIT_TYPE_WIDTH + PAYLOAD_WIDTH;
    localparam int CLK_PERIOD     = 100;
    // cycles per test, a checked read costs two
    localparam int TEST_CYCLES    = 8 + 3 * VC_DEPTH + 3 * NUM_VC * VC_DEPTH
                                    + 9 * VC_DEPTH + 16;
    localparam int TIMEOUT_CYCLES = 2 * (5 + TEST_CYCLES) + 50;

    logic                     clk;
    logic                     reset;
    flit_type_e               flit_type_in;
    logic [PAYLOAD_WIDTH-1:0] payload_in;
    logic                     wr_en;
    logic                     rd_en;
    logic [NUM_VC-1:0]        vc_num_wr;
    logic [NUM_VC-1:0]        vc_num_rd;
    logic [NUM_VC-1:0]        ssa_rd;
    flit_type_e               flit_type_out;
    logic [PAYLOAD_WIDTH-1:0] payload_out;
    logic [NUM_VC-1:0]        vc_not_empty;

    logic [DATA_W-1:0] model_q [NUM_VC][$];  // {type, payload} per vc
    integer            seed;
    int                errors;
    int                tests_run;
    int                tests_failed;

    vc_flit_buffer #(
        .NUM_VC        (NUM_VC),
        .VC_DEPTH      (VC_DEPTH),
        .PAYLOAD_WIDTH (PAYLOAD_WIDTH)
    ) u_vc_flit_buffer (
        .clk           (clk),
        .reset         (reset),
        .flit_type_in  (flit_type_in),
        .payload_in    (payload_in),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .vc_num_wr     (vc_num_wr),
        .vc_num_rd     (vc_num_rd),
        .ssa_rd        (ssa_rd),
        .flit_type_out (flit_type_out),
        .payload_out   (payload_out),
        .vc_not_empty  (vc_not_empty)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_flit(input flit_type_e exp_type,
                              input logic [PAYLOAD_WIDTH-1:0] exp_pay, input string msg);
        if (flit_type_out !== exp_type || payload_out !== exp_pay) begin
            $display("mismatch at %0t: %s, got %s/%h, expected %s/%h", $time, msg,
                     flit_type_out.name(), payload_out, exp_type.name(), exp_pay);
            errors++;
        end
    endtask

    task automatic check_not_empty(input logic [NUM_VC-1:0] exp_flags, input string msg);
        if (vc_not_empty !== exp_flags) begin
            $display("mismatch at %0t: %s, got %b, expected %b", $time, msg,
                     vc_not_empty, exp_flags);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_before);
        tests_run++;
        if (errors == err_before) begin
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d mismatches", name, errors - err_before);
        end
    endtask

    `include "tb_tests.svh"

    initial begin
        seed         = 76;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        reset        <= 1'b1;
        wr_en        <= 1'b0;
        rd_en        <= 1'b0;
        vc_num_wr    <= '0;
        vc_num_rd    <= '0;
        ssa_rd       <= '0;
        flit_type_in <= flit_head;
        payload_in   <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        test_reset_state();
        test_fifo_order();
        test_vc_isolation();
        test_pointer_wrap();
        test_ssa_bypass();
        test_read_write_same_edge();

        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // stops a hung run
    initial begin
        #(TIMEOUT_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Test failures found");
        $finish;
    end

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the vc_flit_buffer testbench with verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing --assert \
    -f vc_flit_buffer.f \
    --top-module tb_vc_flit_buffer \
    -Mdir "$BUILD_DIR" -o sim_vc_flit_buffer
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$BUILD_DIR/sim_vc_flit_buffer" 2>&1 | tee "$LOG_FILE"
sim_status=${PIPESTATUS[0]}
if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failures found" "$LOG_FILE"; then
    echo "simulation reported failures, see $LOG_FILE"
    exit 1
fi

echo "simulation clean, log in $LOG_FILE"
exit 0

//--- vc_flit_buffer.f
+incdir+bench
verilog/flit_buffer_pkg.sv
verilog/flit_ram.sv
verilog/vc_queue_ctrl.sv
verilog/vc_flit_buffer.sv
bench/tb_vc_flit_buffer.sv

//--- verilog/flit_buffer_pkg.sv
package flit_buffer_pkg;

    // flit type field, 2 bits wide on the wire
    localparam int FLIT_TYPE_WIDTH = 2;

    typedef enum logic [FLIT_TYPE_WIDTH-1:0] {
        flit_head   = 2'b00,
        flit_body   = 2'b01,
        flit_tail   = 2'b10,
        flit_single = 2'b11  // head and tail in one flit
    } flit_type_e;

    // defaults handed to the top level parameters
    localparam int DEF_NUM_VC        = 4;
    localparam int DEF_VC_DEPTH      = 4;  // flits per vc, power of 2
    localparam int DEF_PAYLOAD_WIDTH = 32;

endpackage

//--- verilog/flit_ram.sv
`timescale 1ns/1ps

// shared flit memory, registered read with ssa bypass
module flit_ram import flit_buffer_pkg::*; #(
    parameter int NUM_VC        = DEF_NUM_VC,
    parameter int VC_DEPTH      = DEF_VC_DEPTH,
    parameter int PAYLOAD_WIDTH = DEF_PAYLOAD_WIDTH,
    localparam int VC_IDX_W     = (NUM_VC > 1) ? $clog2(NUM_VC) : 1,
    localparam int SLOT_W       = $clog2(VC_DEPTH),
    localparam int ADDR_W       = VC_IDX_W + SLOT_W
) (
    input  logic                     clk,
    input  logic                     wr_en,
    input  logic                     rd_en,
    input  logic [ADDR_W-1:0]        wr_addr,
    input  logic [ADDR_W-1:0]        rd_addr,
    input  flit_type_e               flit_type_in,
    input  logic [PAYLOAD_WIDTH-1:0] payload_in,
    output flit_type_e               flit_type_out,
    output logic [PAYLOAD_WIDTH-1:0] payload_out
);

    localparam int DATA_W = FLIT_TYPE_WIDTH + PAYLOAD_WIDTH;
    localparam int WORDS  = NUM_VC * VC_DEPTH;

    logic [DATA_W-1:0] mem [WORDS];
    logic [DATA_W-1:0] wr_word;
    logic [DATA_W-1:0] rd_q;
    logic [DATA_W-1:0] bypass_q;
    logic [DATA_W-1:0] out_word;
    logic              rd_en_q;

    assign wr_word = {flit_type_in, payload_in};  // type in the top bits

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_word;
        end
        if (rd_en) begin
            rd_q <= mem[rd_addr];  // holds until the next read
        end
        bypass_q <= wr_word;
        rd_en_q  <= rd_en;
    end

    // no read last edge means the output shows last edge's write data
    assign out_word      = rd_en_q ? rd_q : bypass_q;
    assign flit_type_out = flit_type_e'(out_word[DATA_W-1 -: FLIT_TYPE_WIDTH]);
    assign payload_out   = out_word[PAYLOAD_WIDTH-1:0];

endmodule

//--- verilog/vc_flit_buffer.sv
`timescale 1ns/1ps

// router input port buffer, all vcs share one ram
module vc_flit_buffer import flit_buffer_pkg::*; #(
    parameter int NUM_VC        = DEF_NUM_VC,
    parameter int VC_DEPTH      = DEF_VC_DEPTH,
    parameter int PAYLOAD_WIDTH = DEF_PAYLOAD_WIDTH,
    localparam int VC_IDX_W     = (NUM_VC > 1) ? $clog2(NUM_VC) : 1,
    localparam int SLOT_W       = $clog2(VC_DEPTH),
    localparam int ADDR_W       = VC_IDX_W + SLOT_W
) (
    input  logic                     clk,
    input  logic                     reset,
    input  flit_type_e               flit_type_in,
    input  logic [PAYLOAD_WIDTH-1:0] payload_in,
    input  logic                     wr_en,
    input  logic                     rd_en,
    input  logic [NUM_VC-1:0]        vc_num_wr,     // one-hot
    input  logic [NUM_VC-1:0]        vc_num_rd,     // one-hot
    input  logic [NUM_VC-1:0]        ssa_rd,        // speculative read, one bit per vc
    output flit_type_e               flit_type_out,
    output logic [PAYLOAD_WIDTH-1:0] payload_out,
    output logic [NUM_VC-1:0]        vc_not_empty
);

    logic [ADDR_W-1:0] wr_addr;
    logic [ADDR_W-1:0] rd_addr;

    // pointers wrap by overflow, so the depth has to be a power of 2
    if (VC_DEPTH < 2 || (VC_DEPTH & (VC_DEPTH - 1)) != 0) begin : g_depth_check
        $error("VC_DEPTH must be a power of 2 and at least 2");
    end

    vc_queue_ctrl #(
        .NUM_VC   (NUM_VC),
        .VC_DEPTH (VC_DEPTH)
    ) u_queue_ctrl (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .rd_en        (rd_en),
        .vc_num_wr    (vc_num_wr),
        .vc_num_rd    (vc_num_rd),
        .ssa_rd       (ssa_rd),
        .wr_addr      (wr_addr),
        .rd_addr      (rd_addr),
        .vc_not_empty (vc_not_empty)
    );

    flit_ram #(
        .NUM_VC        (NUM_VC),
        .VC_DEPTH      (VC_DEPTH),
        .PAYLOAD_WIDTH (PAYLOAD_WIDTH)
    ) u_ram (
        .clk           (clk),
        .wr_en         (wr_en),
        .rd_en         (rd_en),
        .wr_addr       (wr_addr),
        .rd_addr       (rd_addr),
        .flit_type_in  (flit_type_in),
        .payload_in    (payload_in),
        .flit_type_out (flit_type_out),
        .payload_out   (payload_out)
    );

    // a strobe without exactly one vc would hit the wrong ram slice
    a_wr_onehot: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> $onehot(vc_num_wr));

    a_rd_onehot: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> $onehot(vc_num_rd));

    // ssa only consumes the flit being written this cycle
    a_ssa_with_write: assert property (@(posedge clk) disable iff (reset)
        (!rd_en && |ssa_rd) |-> (wr_en && (ssa_rd & ~vc_num_wr) == '0));

endmodule

//--- verilog/vc_queue_ctrl.sv
`timescale 1ns/1ps

// per-vc pointers and depth counters over a shared ram
module vc_queue_ctrl #(
    parameter int NUM_VC    = 4,
    parameter int VC_DEPTH  = 4,
    localparam int VC_IDX_W = (NUM_VC > 1) ? $clog2(NUM_VC) : 1,
    localparam int SLOT_W   = $clog2(VC_DEPTH),
    localparam int ADDR_W   = VC_IDX_W + SLOT_W,
    localparam int DEPTH_W  = SLOT_W + 1
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              wr_en,
    input  logic              rd_en,
    input  logic [NUM_VC-1:0] vc_num_wr,
    input  logic [NUM_VC-1:0] vc_num_rd,
    input  logic [NUM_VC-1:0] ssa_rd,
    output logic [ADDR_W-1:0] wr_addr,
    output logic [ADDR_W-1:0] rd_addr,
    output logic [NUM_VC-1:0] vc_not_empty
);

    logic [NUM_VC-1:0]   wr_strobe;
    logic [NUM_VC-1:0]   rd_strobe;

    logic [SLOT_W-1:0]   wr_ptr [NUM_VC];
    logic [SLOT_W-1:0]   rd_ptr [NUM_VC];
    logic [DEPTH_W-1:0]  depth  [NUM_VC];

    logic [VC_IDX_W-1:0] wr_idx;
    logic [VC_IDX_W-1:0] rd_idx;
    logic [SLOT_W-1:0]   wr_slot;
    logic [SLOT_W-1:0]   rd_slot;

    assign wr_strobe = wr_en ? vc_num_wr : '0;
    assign rd_strobe = rd_en ? vc_num_rd : ssa_rd;  // ssa counts as a read

    // one-hot select to binary index, plus pointer of the selected vc
    // selects are one-hot, so or-ing the hits is enough
    always_comb begin
        wr_idx  = '0;
        rd_idx  = '0;
        wr_slot = '0;
        rd_slot = '0;
        for (int v = 0; v < NUM_VC; v++) begin
            if (vc_num_wr[v]) begin
                wr_idx  = wr_idx | VC_IDX_W'(v);
                wr_slot = wr_slot | wr_ptr[v];
            end
            if (vc_num_rd[v]) begin
                rd_idx  = rd_idx | VC_IDX_W'(v);
                rd_slot = rd_slot | rd_ptr[v];
            end
        end
    end

    assign wr_addr = {wr_idx, wr_slot};  // vc index picks the slice
    assign rd_addr = {rd_idx, rd_slot};

    for (genvar i = 0; i < NUM_VC; i++) begin : g_vc

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
                depth[i]  <= '0;
            end else begin
                // pointers wrap on their own, depth is a power of 2
                if (wr_strobe[i]) begin
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;
                end
                if (rd_strobe[i]) begin
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
                end

                if (wr_strobe[i] && !rd_strobe[i]) begin
                    depth[i] <= depth[i] + 1'b1;
                end else if (!wr_strobe[i] && rd_strobe[i]) begin
                    depth[i] <= depth[i] - 1'b1;
                end
            end
        end

        assign vc_not_empty[i] = (depth[i] != '0);

        // credits upstream must keep a full vc from being written
        a_no_overflow: assert property (@(posedge clk) disable iff (reset)
            (wr_strobe[i] && depth[i] == DEPTH_W'(VC_DEPTH)) |-> rd_strobe[i]);

        // an empty vc may only be read by ssa on the flit just written
        a_no_underflow: assert property (@(posedge clk) disable iff (reset)
            (rd_strobe[i] && depth[i] == '0) |-> (!rd_en && wr_strobe[i]));

    end

endmodule
